// ==== Bender.yml ====
package:
  name: pst_preg_entry

sources:
  - logic/pst_pkg.sv
  - logic/pst_create_select.sv
  - logic/pst_retire_match.sv
  - logic/pst_lifecycle_fsm.sv
  - logic/pst_status_decode.sv
  - logic/pst_preg_entry.sv
  - target: test
    files:
      - testbench/pst_entry_properties.sv
      - testbench/pst_tb.sv

// ==== logic/pst_create_select.sv ====
/*
 * Entry creation select
 * Picks the one-hot dispatch slot and holds the entry's iid,
 * destination and released physical register until the next create
 */
`timescale 1ns/10ps

module pst_create_select #(
  parameter int NUM_DISPATCH = 4
) (
  input  logic                 sm_clk,
  input  logic                 cpurst_b,
  input  logic [NUM_DISPATCH-1:0] create_vld,
  input  pst_pkg::iid_t        dis_iid      [NUM_DISPATCH],
  input  pst_pkg::areg_t       dis_dst_reg  [NUM_DISPATCH],
  input  pst_pkg::preg_t       dis_rel_preg [NUM_DISPATCH],
  output logic                 create_pulse,
  output pst_pkg::iid_t        entry_iid,
  output pst_pkg::areg_t       entry_dst_reg,
  output pst_pkg::preg_t       entry_rel_preg
);

  import pst_pkg::*;

  iid_t  sel_iid;
  areg_t sel_dst_reg;
  preg_t sel_rel_preg;

  assign create_pulse = |create_vld;

  // AND-OR mux, valid is zero or one-hot
  always_comb begin
    sel_iid      = '0;
    sel_dst_reg  = '0;
    sel_rel_preg = '0;
    for (int i = 0; i < NUM_DISPATCH; i++) begin
      sel_iid      |= dis_iid[i]      & {IID_W{create_vld[i]}};
      sel_dst_reg  |= dis_dst_reg[i]  & {AREG_W{create_vld[i]}};
      sel_rel_preg |= dis_rel_preg[i] & {PREG_W{create_vld[i]}};
    end
  end

  // Information register
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      entry_iid      <= '0;
      entry_dst_reg  <= '0;
      entry_rel_preg <= '0;
    end else if (create_pulse) begin
      entry_iid      <= sel_iid;
      entry_dst_reg  <= sel_dst_reg;
      entry_rel_preg <= sel_rel_preg;
    end
  end

endmodule

// ==== logic/pst_lifecycle_fsm.sv ====
/*
 * Lifecycle and write-back state machines
 * Tracks one physical register from dealloc through release and
 * whether its value has been written back
 */
`timescale 1ns/10ps

module pst_lifecycle_fsm (
  input  logic                      sm_clk,
  input  logic                      cpurst_b,
  input  logic                      flush,
  input  logic                      async_flush,
  input  logic                      dealloc_vld,
  input  logic                      dealloc_mask,
  input  logic                      release_vld,
  input  logic                      wb_vld,
  input  logic                      create_pulse,
  input  logic                      retire_hit,
  output pst_pkg::lifecycle_state_e lifecycle_state,
  output pst_pkg::wb_state_e        wb_state
);

  import pst_pkg::*;

  lifecycle_state_e lifecycle_next;
  wb_state_e        wb_next;
  logic             wb_done_masked;

  // Written back and not held by the dealloc mask
  assign wb_done_masked = (wb_state == WB_DONE) && !dealloc_mask;

  //==========================================================
  // Lifecycle FSM
  //==========================================================
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      lifecycle_state <= DEALLOC;
    end else begin
      lifecycle_state <= lifecycle_next;
    end
  end

  always_comb begin
    lifecycle_next = lifecycle_state;
    case (lifecycle_state)
      DEALLOC: begin
        if (dealloc_vld && !flush) lifecycle_next = WF_ALLOC;
      end
      WF_ALLOC: begin
        if (flush)             lifecycle_next = DEALLOC;
        else if (create_pulse) lifecycle_next = ALLOC;
      end
      ALLOC: begin
        if (flush)                               lifecycle_next = DEALLOC;
        else if (release_vld && wb_done_masked)  lifecycle_next = DEALLOC;
        else if (release_vld)                    lifecycle_next = RELEASE;
        else if (retire_hit)                     lifecycle_next = RETIRE;
      end
      RETIRE: begin
        if (release_vld && wb_done_masked) lifecycle_next = DEALLOC;
        else if (release_vld)              lifecycle_next = RELEASE;
      end
      RELEASE: begin
        if (wb_done_masked) lifecycle_next = DEALLOC;
      end
      default: lifecycle_next = DEALLOC;
    endcase
  end

  //==========================================================
  // Write-back FSM
  //==========================================================
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      wb_state <= WB_IDLE;
    end else begin
      wb_state <= wb_next;
    end
  end

  // Async flush wins, a new producer clears the old write-back
  always_comb begin
    wb_next = wb_state;
    if (async_flush) begin
      wb_next = WB_DONE;
    end else if (create_pulse) begin
      wb_next = WB_IDLE;
    end else if (wb_state == WB_IDLE) begin
      if (wb_vld) wb_next = WB_DONE;
    end else if (lifecycle_state == DEALLOC) begin
      wb_next = WB_IDLE;
    end
  end

endmodule

// ==== logic/pst_pkg.sv ====
/*
 * Physical register status table, shared definitions
 * Register counts, index widths, one-hot vector types and the
 * encodings of the lifecycle and write-back state machines
 */
package pst_pkg;

  // Register file sizes
  localparam int PREG_NUM = 96;
  localparam int AREG_NUM = 32;

  // Index widths
  localparam int PREG_W = 7;
  localparam int AREG_W = 5;
  localparam int IID_W  = 7;

  typedef logic [PREG_W-1:0]   preg_t;
  typedef logic [AREG_W-1:0]   areg_t;
  typedef logic [IID_W-1:0]    iid_t;

  // One bit per register, used by the release and recovery buses
  typedef logic [PREG_NUM-1:0] preg_vec_t;
  typedef logic [AREG_NUM-1:0] areg_vec_t;

  //==========================================================
  // Lifecycle of one physical register, one-hot
  //==========================================================
  typedef enum logic [4:0] {
    DEALLOC  = 5'b00001,
    WF_ALLOC = 5'b00010,
    ALLOC    = 5'b00100,
    RETIRE   = 5'b01000,
    RELEASE  = 5'b10000
  } lifecycle_state_e;

  // Write-back tracking
  typedef enum logic {
    WB_IDLE = 1'b0,
    WB_DONE = 1'b1
  } wb_state_e;

endpackage

// ==== logic/pst_preg_entry.sv ====
/*
 * Physical register status table entry
 * Top level of one entry, connects creation select, retire match,
 * lifecycle state machines and status decode
 */
`timescale 1ns/10ps

module pst_preg_entry #(
  parameter int NUM_DISPATCH = 4,
  parameter int NUM_RETIRE   = 3
) (
  input  logic                    sm_clk,
  input  logic                    cpurst_b,
  input  logic                    flush,
  input  logic                    async_flush,
  input  logic                    dealloc_vld,
  input  logic                    dealloc_mask,
  input  logic                    release_vld,
  input  logic                    wb_vld,
  input  logic [NUM_DISPATCH-1:0] create_vld,
  input  pst_pkg::iid_t           dis_iid      [NUM_DISPATCH],
  input  pst_pkg::areg_t          dis_dst_reg  [NUM_DISPATCH],
  input  pst_pkg::preg_t          dis_rel_preg [NUM_DISPATCH],
  input  logic [NUM_RETIRE-1:0]   retire_iid_updt_vld,
  input  pst_pkg::iid_t           retire_iid_updt_val [NUM_RETIRE],
  input  logic [NUM_RETIRE-1:0]   retire_preg_vld,
  output logic                    cur_state_dealloc,
  output pst_pkg::areg_vec_t      dreg,
  output pst_pkg::preg_vec_t      rel_preg_expand,
  output logic                    retired_released_wb
);

  import pst_pkg::*;

  logic             create_pulse;
  iid_t             entry_iid;
  areg_t            entry_dst_reg;
  preg_t            entry_rel_preg;
  logic             retire_hit;
  logic             state_alloc;
  lifecycle_state_e lifecycle_state;
  wb_state_e        wb_state;

  // ALLOC bit of the one-hot lifecycle state
  assign state_alloc = lifecycle_state[2];

  //==========================================================
  // Input side
  //==========================================================
  pst_create_select #(.NUM_DISPATCH(NUM_DISPATCH)) u_create_select (
    .sm_clk         (sm_clk),
    .cpurst_b       (cpurst_b),
    .create_vld     (create_vld),
    .dis_iid        (dis_iid),
    .dis_dst_reg    (dis_dst_reg),
    .dis_rel_preg   (dis_rel_preg),
    .create_pulse   (create_pulse),
    .entry_iid      (entry_iid),
    .entry_dst_reg  (entry_dst_reg),
    .entry_rel_preg (entry_rel_preg)
  );

  pst_retire_match #(.NUM_RETIRE(NUM_RETIRE)) u_retire_match (
    .sm_clk              (sm_clk),
    .cpurst_b            (cpurst_b),
    .entry_iid           (entry_iid),
    .state_alloc         (state_alloc),
    .retire_iid_updt_vld (retire_iid_updt_vld),
    .retire_iid_updt_val (retire_iid_updt_val),
    .retire_preg_vld     (retire_preg_vld),
    .retire_hit          (retire_hit)
  );

  //==========================================================
  // State machines and output decode
  //==========================================================
  pst_lifecycle_fsm u_lifecycle_fsm (
    .sm_clk          (sm_clk),
    .cpurst_b        (cpurst_b),
    .flush           (flush),
    .async_flush     (async_flush),
    .dealloc_vld     (dealloc_vld),
    .dealloc_mask    (dealloc_mask),
    .release_vld     (release_vld),
    .wb_vld          (wb_vld),
    .create_pulse    (create_pulse),
    .retire_hit      (retire_hit),
    .lifecycle_state (lifecycle_state),
    .wb_state        (wb_state)
  );

  pst_status_decode u_status_decode (
    .lifecycle_state     (lifecycle_state),
    .wb_state            (wb_state),
    .retire_hit          (retire_hit),
    .entry_dst_reg       (entry_dst_reg),
    .entry_rel_preg      (entry_rel_preg),
    .cur_state_dealloc   (cur_state_dealloc),
    .dreg                (dreg),
    .rel_preg_expand     (rel_preg_expand),
    .retired_released_wb (retired_released_wb)
  );

endmodule

// ==== logic/pst_retire_match.sv ====
/*
 * Retire iid pre-compare
 * Matches the stored iid against each retire slot one cycle early
 * and forms the retire pulse from the retire confirmations
 */
`timescale 1ns/10ps

module pst_retire_match #(
  parameter int NUM_RETIRE = 3
) (
  input  logic                  sm_clk,
  input  logic                  cpurst_b,
  input  pst_pkg::iid_t         entry_iid,
  input  logic                  state_alloc,
  input  logic [NUM_RETIRE-1:0] retire_iid_updt_vld,
  input  pst_pkg::iid_t         retire_iid_updt_val [NUM_RETIRE],
  input  logic [NUM_RETIRE-1:0] retire_preg_vld,
  output logic                  retire_hit
);

  logic [NUM_RETIRE-1:0] match_updt_val;
  logic [NUM_RETIRE-1:0] iid_match;

  //==========================================================
  // Compare ahead of retire
  //==========================================================
  // Only an allocated entry can have a retiring producer
  always_comb begin
    for (int k = 0; k < NUM_RETIRE; k++) begin
      match_updt_val[k] = state_alloc && (entry_iid == retire_iid_updt_val[k]);
    end
  end

  // Each slot flag updates only on its own update pulse
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      iid_match <= '0;
    end else begin
      for (int k = 0; k < NUM_RETIRE; k++) begin
        if (retire_iid_updt_vld[k]) begin
          iid_match[k] <= match_updt_val[k];
        end
      end
    end
  end

  //==========================================================
  // Retire confirmation
  //==========================================================
  assign retire_hit = |(retire_preg_vld & iid_match);

endmodule

// ==== logic/pst_status_decode.sv ====
/*
 * Status decode
 * Expands the stored indices into state-gated one-hot vectors and
 * forms the retired-or-released write-back flag
 */
`timescale 1ns/10ps

module pst_status_decode (
  input  pst_pkg::lifecycle_state_e lifecycle_state,
  input  pst_pkg::wb_state_e        wb_state,
  input  logic                      retire_hit,
  input  pst_pkg::areg_t            entry_dst_reg,
  input  pst_pkg::preg_t            entry_rel_preg,
  output logic                      cur_state_dealloc,
  output pst_pkg::areg_vec_t        dreg,
  output pst_pkg::preg_vec_t        rel_preg_expand,
  output logic                      retired_released_wb
);

  import pst_pkg::*;

  logic rel_retire_vld;
  logic state_retire;
  logic state_release;

  assign cur_state_dealloc = (lifecycle_state == DEALLOC);
  assign state_retire      = (lifecycle_state == RETIRE);
  assign state_release     = (lifecycle_state == RELEASE);

  // Producer retires this cycle, the old mapping is freed
  assign rel_retire_vld = (lifecycle_state == ALLOC) && retire_hit;

  assign rel_preg_expand = rel_retire_vld ? (preg_vec_t'(1) << entry_rel_preg) : '0;

  // Rename table recovery while retired
  assign dreg = state_retire ? (areg_vec_t'(1) << entry_dst_reg) : '0;

  //==========================================================
  // Write-back flag for the flush logic
  //==========================================================
  // Includes the entry retiring in this very cycle
  assign retired_released_wb = (rel_retire_vld || state_retire || state_release)
                               ? (wb_state == WB_DONE) : 1'b1;

endmodule

// ==== tb.f ====
logic/pst_pkg.sv
logic/pst_create_select.sv
logic/pst_retire_match.sv
logic/pst_lifecycle_fsm.sv
logic/pst_status_decode.sv
logic/pst_preg_entry.sv
testbench/pst_entry_properties.sv
testbench/pst_tb.sv

// ==== testbench/pst_entry_properties.sv ====
/*
 * Bound assertions on the entry outputs
 * One-hot shape of both vectors and their consistency with dealloc
 */
`timescale 1ns/10ps

module pst_entry_properties (
  input logic               sm_clk,
  input logic               cpurst_b,
  input logic               cur_state_dealloc,
  input pst_pkg::areg_vec_t dreg,
  input pst_pkg::preg_vec_t rel_preg_expand
);

  int fail_cnt = 0;

  dreg_onehot: assert property (@(posedge sm_clk) disable iff (!cpurst_b)
    $onehot0(dreg))
  else begin
    fail_cnt++;
    $error("dreg is neither zero nor one-hot");
  end

  rel_onehot: assert property (@(posedge sm_clk) disable iff (!cpurst_b)
    $onehot0(rel_preg_expand))
  else begin
    fail_cnt++;
    $error("rel_preg_expand is neither zero nor one-hot");
  end

  // No recovery vector from a free entry
  dealloc_no_dreg: assert property (@(posedge sm_clk) disable iff (!cpurst_b)
    cur_state_dealloc |-> (dreg == '0))
  else begin
    fail_cnt++;
    $error("dreg is set while the entry is deallocated");
  end

  rel_not_dealloc: assert property (@(posedge sm_clk) disable iff (!cpurst_b)
    (rel_preg_expand != '0) |-> !cur_state_dealloc)
  else begin
    fail_cnt++;
    $error("release vector is set while the entry is deallocated");
  end

endmodule

bind pst_preg_entry pst_entry_properties u_entry_properties (
  .sm_clk            (sm_clk),
  .cpurst_b          (cpurst_b),
  .cur_state_dealloc (cur_state_dealloc),
  .dreg              (dreg),
  .rel_preg_expand   (rel_preg_expand)
);

// ==== testbench/pst_tb.sv ====
/*
 * Testbench for one physical register status table entry
 * Directed lifecycle sequences and a seeded random run, checked
 * every cycle against a reference model of the entry
 */
`timescale 1ns/10ps

module pst_tb;

  import pst_pkg::*;

  localparam int NUM_DISPATCH = 4;
  localparam int NUM_RETIRE   = 3;
  localparam int NUM_CYCLES   = 2000;
  localparam int CLK_PERIOD   = 100;
  localparam int WATCHDOG_NS  = NUM_CYCLES * CLK_PERIOD * 3 / 2;
  localparam int SEED         = 87444;

  logic                    sm_clk;
  logic                    cpurst_b;
  logic                    flush;
  logic                    async_flush;
  logic                    dealloc_vld;
  logic                    dealloc_mask;
  logic                    release_vld;
  logic                    wb_vld;
  logic [NUM_DISPATCH-1:0] create_vld;
  iid_t                    dis_iid      [NUM_DISPATCH];
  areg_t                   dis_dst_reg  [NUM_DISPATCH];
  preg_t                   dis_rel_preg [NUM_DISPATCH];
  logic [NUM_RETIRE-1:0]   retire_iid_updt_vld;
  iid_t                    retire_iid_updt_val [NUM_RETIRE];
  logic [NUM_RETIRE-1:0]   retire_preg_vld;
  logic                    cur_state_dealloc;
  areg_vec_t               dreg;
  preg_vec_t               rel_preg_expand;
  logic                    retired_released_wb;

  // Reference model state
  lifecycle_state_e        m_state;
  wb_state_e               m_wb;
  iid_t                    m_iid;
  areg_t                   m_dst;
  preg_t                   m_rel;
  logic [NUM_RETIRE-1:0]   m_match;
  int                      err_cnt = 0;

  pst_preg_entry #(.NUM_DISPATCH(NUM_DISPATCH), .NUM_RETIRE(NUM_RETIRE)) i_dut (.*);

  initial begin
    sm_clk = 1'b0;
    forever #(CLK_PERIOD / 2) sm_clk = ~sm_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not complete within %0d ns", WATCHDOG_NS);
    $display("TB FAILED");
    $finish;
  end

  function automatic preg_vec_t one_hot(input int idx);
    preg_vec_t v;
    v      = '0;
    v[idx] = 1'b1;
    return v;
  endfunction

  task automatic check_value(input string name, input preg_vec_t exp_val,
                             input preg_vec_t act_val);
    assert (act_val === exp_val)
    else begin
      err_cnt++;
      $display("[FAIL] %0d ns %s expected %h actual %h", $time, name, exp_val, act_val);
    end
  endtask

  //============================================================
  // Reference model, next state on every rising edge
  //============================================================
  always @(posedge sm_clk or negedge cpurst_b) begin
    logic hit;
    logic create;
    logic wb_ok;
    if (!cpurst_b) begin
      m_state <= DEALLOC;
      m_wb    <= WB_IDLE;
      m_iid   <= '0;
      m_dst   <= '0;
      m_rel   <= '0;
      m_match <= '0;
    end else begin
      hit    = |(retire_preg_vld & m_match);
      create = |create_vld;
      wb_ok  = (m_wb == WB_DONE) && !dealloc_mask;
      case (m_state)
        DEALLOC: begin
          if (dealloc_vld && !flush) m_state <= WF_ALLOC;
        end
        WF_ALLOC: begin
          if (flush) m_state <= DEALLOC;
          else if (create) m_state <= ALLOC;
        end
        ALLOC: begin
          if (flush || (release_vld && wb_ok)) m_state <= DEALLOC;
          else if (release_vld) m_state <= RELEASE;
          else if (hit) m_state <= RETIRE;
        end
        RETIRE: begin
          if (release_vld && wb_ok) m_state <= DEALLOC;
          else if (release_vld) m_state <= RELEASE;
        end
        default: begin
          if (wb_ok) m_state <= DEALLOC;
        end
      endcase
      if (async_flush) m_wb <= WB_DONE;
      else if (create) m_wb <= WB_IDLE;
      else if (m_wb == WB_IDLE && wb_vld) m_wb <= WB_DONE;
      else if (m_wb == WB_DONE && m_state == DEALLOC) m_wb <= WB_IDLE;
      for (int i = 0; i < NUM_DISPATCH; i++) begin
        if (create_vld[i]) begin
          m_iid <= dis_iid[i];
          m_dst <= dis_dst_reg[i];
          m_rel <= dis_rel_preg[i];
        end
      end
      for (int k = 0; k < NUM_RETIRE; k++) begin
        if (retire_iid_updt_vld[k]) begin
          m_match[k] <= (m_state == ALLOC) && (m_iid == retire_iid_updt_val[k]);
        end
      end
    end
  end

  // Outputs are stable after the falling edge
  always @(negedge sm_clk) begin
    logic      hit;
    logic      exp_rrwb;
    preg_vec_t exp_rel;
    areg_vec_t exp_dreg;
    if (cpurst_b) begin
      hit      = |(retire_preg_vld & m_match);
      exp_rel  = (m_state == ALLOC && hit) ? one_hot(m_rel) : '0;
      exp_dreg = (m_state == RETIRE) ? areg_vec_t'(one_hot(m_dst)) : '0;
      exp_rrwb = ((m_state == ALLOC && hit) || m_state == RETIRE || m_state == RELEASE)
                 ? (m_wb == WB_DONE) : 1'b1;
      check_value("cur_state_dealloc", m_state == DEALLOC, cur_state_dealloc);
      check_value("dreg", exp_dreg, dreg);
      check_value("rel_preg_expand", exp_rel, rel_preg_expand);
      check_value("retired_released_wb", exp_rrwb, retired_released_wb);
    end
  end

  //============================================================
  // Stimulus tasks
  //============================================================
  task automatic clear_inputs();
    flush               <= 1'b0;
    async_flush         <= 1'b0;
    dealloc_vld         <= 1'b0;
    dealloc_mask        <= 1'b0;
    release_vld         <= 1'b0;
    wb_vld              <= 1'b0;
    create_vld          <= '0;
    retire_iid_updt_vld <= '0;
    retire_preg_vld     <= '0;
  endtask

  task automatic next_cycle();
    @(posedge sm_clk);
    clear_inputs();
  endtask

  // Dealloc, then create from a random slot; returns that slot's fields
  task automatic alloc_entry(output iid_t iid, output areg_t dst, output preg_t rel);
    int slot;
    next_cycle();
    dealloc_vld <= 1'b1;
    next_cycle();
    slot = $urandom % NUM_DISPATCH;
    iid  = iid_t'($urandom);
    dst  = areg_t'($urandom);
    rel  = preg_t'($urandom % PREG_NUM);
    for (int i = 0; i < NUM_DISPATCH; i++) begin
      dis_iid[i]      <= (i == slot) ? iid : iid_t'($urandom);
      dis_dst_reg[i]  <= (i == slot) ? dst : areg_t'($urandom);
      dis_rel_preg[i] <= (i == slot) ? rel : preg_t'($urandom % PREG_NUM);
    end
    create_vld[slot] <= 1'b1;
  endtask

  // Update pulse, then confirmation on slot k
  task automatic retire_slot(input iid_t val, input int k, input preg_vec_t exp_rel);
    next_cycle();
    retire_iid_updt_vld[k] <= 1'b1;
    retire_iid_updt_val[k] <= val;
    next_cycle();
    retire_preg_vld[k] <= 1'b1;
    @(negedge sm_clk);
    check_value("rel_preg_expand", exp_rel, rel_preg_expand);
  endtask

  task automatic drive_random();
    int slot;
    clear_inputs();
    flush        <= ($urandom % 16) == 0;
    async_flush  <= ($urandom % 32) == 0;
    dealloc_vld  <= ($urandom % 4) == 0;
    dealloc_mask <= ($urandom % 4) == 0;
    release_vld  <= ($urandom % 8) == 0;
    wb_vld       <= ($urandom % 4) == 0;
    slot = $urandom % NUM_DISPATCH;
    if (($urandom % 4) == 0) create_vld[slot] <= 1'b1;
    for (int i = 0; i < NUM_DISPATCH; i++) begin
      dis_iid[i]      <= iid_t'($urandom);
      dis_dst_reg[i]  <= areg_t'($urandom);
      dis_rel_preg[i] <= preg_t'($urandom % PREG_NUM);
    end
    // Half of the updates carry the stored iid
    for (int k = 0; k < NUM_RETIRE; k++) begin
      retire_iid_updt_vld[k] <= ($urandom % 4) == 0;
      retire_iid_updt_val[k] <= ($urandom % 2) ? m_iid : iid_t'($urandom);
      retire_preg_vld[k]     <= ($urandom % 4) == 0;
    end
  endtask

  //============================================================
  // Test sequence
  //============================================================
  initial begin
    iid_t  iid;
    areg_t dst;
    preg_t rel;
    int    k;
    int    seed;
    int    total_err;
    seed = SEED;
    void'($urandom(seed));
    cpurst_b = 1'b0;
    clear_inputs();
    for (int i = 0; i < NUM_DISPATCH; i++) begin
      dis_iid[i]      <= '0;
      dis_dst_reg[i]  <= '0;
      dis_rel_preg[i] <= '0;
    end
    for (int j = 0; j < NUM_RETIRE; j++) retire_iid_updt_val[j] <= '0;
    repeat (3) @(posedge sm_clk);
    cpurst_b <= 1'b1;
    @(negedge sm_clk);
    check_value("cur_state_dealloc", 1, cur_state_dealloc);
    check_value("dreg", '0, dreg);
    check_value("rel_preg_expand", '0, rel_preg_expand);
    check_value("retired_released_wb", 1, retired_released_wb);

    // Create, retire, then release held off by the dealloc mask
    alloc_entry(iid, dst, rel);
    k = $urandom % NUM_RETIRE;
    retire_slot(iid, k, one_hot(rel));
    next_cycle();
    @(negedge sm_clk);
    check_value("dreg", one_hot(dst), dreg);
    next_cycle();
    wb_vld <= 1'b1;
    next_cycle();
    release_vld  <= 1'b1;
    dealloc_mask <= 1'b1;
    next_cycle();
    dealloc_mask <= 1'b1;
    @(negedge sm_clk);
    check_value("cur_state_dealloc", 0, cur_state_dealloc);
    next_cycle();
    @(negedge sm_clk);
    check_value("cur_state_dealloc", 0, cur_state_dealloc);
    next_cycle();
    @(negedge sm_clk);
    check_value("cur_state_dealloc", 1, cur_state_dealloc);

    // Release without write-back waits for wb_vld
    alloc_entry(iid, dst, rel);
    retire_slot(iid, $urandom % NUM_RETIRE, one_hot(rel));
    next_cycle();
    release_vld <= 1'b1;
    next_cycle();
    @(negedge sm_clk);
    check_value("retired_released_wb", 0, retired_released_wb);
    next_cycle();
    wb_vld <= 1'b1;
    next_cycle();
    next_cycle();
    @(negedge sm_clk);
    check_value("cur_state_dealloc", 1, cur_state_dealloc);

    // Flush in WF_ALLOC, then in ALLOC
    next_cycle();
    dealloc_vld <= 1'b1;
    next_cycle();
    flush <= 1'b1;
    next_cycle();
    @(negedge sm_clk);
    check_value("cur_state_dealloc", 1, cur_state_dealloc);
    alloc_entry(iid, dst, rel);
    next_cycle();
    flush <= 1'b1;
    next_cycle();
    @(negedge sm_clk);
    check_value("cur_state_dealloc", 1, cur_state_dealloc);

    // Async flush while retired
    alloc_entry(iid, dst, rel);
    retire_slot(iid, $urandom % NUM_RETIRE, one_hot(rel));
    next_cycle();
    async_flush <= 1'b1;
    next_cycle();
    @(negedge sm_clk);
    check_value("retired_released_wb", 1, retired_released_wb);
    next_cycle();
    release_vld <= 1'b1;

    // Confirmation after a mismatching update
    alloc_entry(iid, dst, rel);
    retire_slot(iid_t'(iid + 1'b1), $urandom % NUM_RETIRE, '0);
    next_cycle();
    @(negedge sm_clk);
    check_value("dreg", '0, dreg);
    check_value("cur_state_dealloc", 0, cur_state_dealloc);
    next_cycle();
    flush <= 1'b1;

    repeat (NUM_CYCLES) begin
      @(posedge sm_clk);
      drive_random();
    end
    next_cycle();
    @(negedge sm_clk);

    total_err = err_cnt + i_dut.u_entry_properties.fail_cnt;
    $display("Value errors: %0d, assertion errors: %0d", err_cnt,
             i_dut.u_entry_properties.fail_cnt);
    if (total_err == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
